//--- Makefile
# Verilator build and run for the SRAM arbiter testbench.

VERILATOR ?= verilator
TOP       ?= sramArbiterTb
FILELIST  ?= sramArbiter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/accessTimer.sv
`timescale 1ns/100ps

module accessTimer #(
  parameter int accessLatency = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic busy,
  output logic done
);

  localparam int cntWidth = (accessLatency < 1) ? 1 : $clog2(accessLatency + 1);

  logic [cntWidth-1:0] count;

  assign busy = (count != '0);

  // done follows the edge where the count reaches zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= (count == cntWidth'(1));
      if (start) begin
        count <= cntWidth'(accessLatency);
      end else if (busy) begin
        count <= count - cntWidth'(1);
      end
    end
  end

endmodule

//--- hw/channelRouter.sv
`timescale 1ns/100ps

module channelRouter import sramArbPkg::*; #(
  parameter type reqT  = readReq,
  parameter type respT = readResp
) (
  input  grantState grant,
  input  reqT       reqA,
  input  logic      reqValidA,
  input  reqT       reqB,
  input  logic      reqValidB,
  input  logic      respReadyA,
  input  logic      respReadyB,
  input  logic      slvReqReady,
  input  respT      slvResp,
  input  logic      slvRespValid,
  output logic      reqReadyA,
  output logic      reqReadyB,
  output respT      respA,
  output logic      respValidA,
  output respT      respB,
  output logic      respValidB,
  output reqT       slvReq,
  output logic      slvReqValid,
  output logic      slvRespReady
);

  always_comb begin
    // ungranted side sees nothing but an error code.
    slvReq       = '0;
    slvReqValid  = 1'b0;
    slvRespReady = 1'b0;
    reqReadyA    = 1'b0;
    reqReadyB    = 1'b0;
    respA        = '0;
    respB        = '0;
    respA.resp   = respSlvErr;
    respB.resp   = respSlvErr;
    respValidA   = 1'b0;
    respValidB   = 1'b0;
    case (grant)
      grantA: begin
        slvReq       = reqA;
        slvReqValid  = reqValidA;
        reqReadyA    = slvReqReady;
        respA        = slvResp;
        respValidA   = slvRespValid;
        slvRespReady = respReadyA;
      end
      grantB: begin
        slvReq       = reqB;
        slvReqValid  = reqValidB;
        reqReadyB    = slvReqReady;
        respB        = slvResp;
        respValidB   = slvRespValid;
        slvRespReady = respReadyB;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hw/grantFsm.sv
`timescale 1ns/100ps

module grantFsm import sramArbPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      reqValidA,
  input  logic      reqValidB,
  input  logic      respValid,
  input  logic      respReady,
  output grantState grant
);

  grantState nextGrant;
  logic      respDone;

  // the routed response handshake closes the transaction.
  assign respDone = respValid && respReady;

  // ==================================================
  // next state.
  // ==================================================
  always_comb begin
    nextGrant = grant;
    case (grant)
      grantIdle: begin
        // master A has fixed priority.
        if (reqValidA) begin
          nextGrant = grantA;
        end else if (reqValidB) begin
          nextGrant = grantB;
        end
      end
      grantA: begin
        if (respDone) begin
          nextGrant = grantIdle;
        end
      end
      grantB: begin
        if (respDone) begin
          nextGrant = grantIdle;
        end
      end
      default: begin
        nextGrant = grantIdle;
      end
    endcase
  end

  // ==================================================
  // state register.
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= grantIdle;
    end else begin
      grant <= nextGrant;
    end
  end

endmodule

//--- hw/sramArbPkg.sv
package sramArbPkg;

  // ==================================================
  // bus widths.
  // ==================================================
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int strbWidth = 4;

  // ==================================================
  // encodings.
  // ==================================================
  typedef enum logic [1:0] {
    respOkay   = 2'd0,
    respSlvErr = 2'd2
  } respCode;

  typedef enum logic [1:0] {
    grantIdle,
    grantA,
    grantB
  } grantState;

  // current operation of the single array port.
  typedef enum logic [1:0] {
    opNone,
    opRead,
    opWrite
  } sramOp;

  // ==================================================
  // channel payloads.
  // ==================================================
  typedef struct packed {
    logic [addrWidth-1:0] addr;
  } readReq;

  typedef struct packed {
    logic [dataWidth-1:0] data;
    respCode              resp;
  } readResp;

  // address and data travel together as one write request.
  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
    logic [strbWidth-1:0] strb;
  } writeReq;

  typedef struct packed {
    respCode resp;
  } writeResp;

endpackage

//--- hw/sramArbiter.sv
`timescale 1ns/100ps

module sramArbiter import sramArbPkg::*; #(
  parameter int accessLatency = 3,
  parameter int memWords      = 1024
) (
  input  logic     clk,
  input  logic     rst,
  // master A, instruction fetch.
  input  readReq   readReqA,
  input  logic     readReqValidA,
  input  logic     readRespReadyA,
  input  writeReq  writeReqA,
  input  logic     writeReqValidA,
  input  logic     writeRespReadyA,
  output logic     readReqReadyA,
  output readResp  readRespA,
  output logic     readRespValidA,
  output logic     writeReqReadyA,
  output writeResp writeRespA,
  output logic     writeRespValidA,
  // master B, load/store.
  input  readReq   readReqB,
  input  logic     readReqValidB,
  input  logic     readRespReadyB,
  input  writeReq  writeReqB,
  input  logic     writeReqValidB,
  input  logic     writeRespReadyB,
  output logic     readReqReadyB,
  output readResp  readRespB,
  output logic     readRespValidB,
  output logic     writeReqReadyB,
  output writeResp writeRespB,
  output logic     writeRespValidB
);

  grantState readGrantState;
  grantState writeGrantState;

  readReq   slvReadReq;
  logic     slvReadReqValid;
  logic     slvReadReqReady;
  readResp  slvReadResp;
  logic     slvReadRespValid;
  logic     slvReadRespReady;
  writeReq  slvWriteReq;
  logic     slvWriteReqValid;
  logic     slvWriteReqReady;
  writeResp slvWriteResp;
  logic     slvWriteRespValid;
  logic     slvWriteRespReady;

  // ==================================================
  // read path.
  // ==================================================
  grantFsm readGrant (
    .clk      (clk),
    .rst      (rst),
    .reqValidA(readReqValidA),
    .reqValidB(readReqValidB),
    .respValid(slvReadRespValid),
    .respReady(slvReadRespReady),
    .grant    (readGrantState)
  );

  channelRouter #(
    .reqT (readReq),
    .respT(readResp)
  ) readRouter (
    .grant       (readGrantState),
    .reqA        (readReqA),
    .reqValidA   (readReqValidA),
    .reqB        (readReqB),
    .reqValidB   (readReqValidB),
    .respReadyA  (readRespReadyA),
    .respReadyB  (readRespReadyB),
    .slvReqReady (slvReadReqReady),
    .slvResp     (slvReadResp),
    .slvRespValid(slvReadRespValid),
    .reqReadyA   (readReqReadyA),
    .reqReadyB   (readReqReadyB),
    .respA       (readRespA),
    .respValidA  (readRespValidA),
    .respB       (readRespB),
    .respValidB  (readRespValidB),
    .slvReq      (slvReadReq),
    .slvReqValid (slvReadReqValid),
    .slvRespReady(slvReadRespReady)
  );

  // ==================================================
  // write path.
  // ==================================================
  grantFsm writeGrant (
    .clk      (clk),
    .rst      (rst),
    .reqValidA(writeReqValidA),
    .reqValidB(writeReqValidB),
    .respValid(slvWriteRespValid),
    .respReady(slvWriteRespReady),
    .grant    (writeGrantState)
  );

  channelRouter #(
    .reqT (writeReq),
    .respT(writeResp)
  ) writeRouter (
    .grant       (writeGrantState),
    .reqA        (writeReqA),
    .reqValidA   (writeReqValidA),
    .reqB        (writeReqB),
    .reqValidB   (writeReqValidB),
    .respReadyA  (writeRespReadyA),
    .respReadyB  (writeRespReadyB),
    .slvReqReady (slvWriteReqReady),
    .slvResp     (slvWriteResp),
    .slvRespValid(slvWriteRespValid),
    .reqReadyA   (writeReqReadyA),
    .reqReadyB   (writeReqReadyB),
    .respA       (writeRespA),
    .respValidA  (writeRespValidA),
    .respB       (writeRespB),
    .respValidB  (writeRespValidB),
    .slvReq      (slvWriteReq),
    .slvReqValid (slvWriteReqValid),
    .slvRespReady(slvWriteRespReady)
  );

  // shared single-ported array.
  sramSlave #(
    .accessLatency(accessLatency),
    .memWords     (memWords)
  ) sram (
    .clk           (clk),
    .rst           (rst),
    .readReqIn     (slvReadReq),
    .readReqValid  (slvReadReqValid),
    .writeReqIn    (slvWriteReq),
    .writeReqValid (slvWriteReqValid),
    .readRespReady (slvReadRespReady),
    .writeRespReady(slvWriteRespReady),
    .readReqReady  (slvReadReqReady),
    .writeReqReady (slvWriteReqReady),
    .readRespOut   (slvReadResp),
    .readRespValid (slvReadRespValid),
    .writeRespOut  (slvWriteResp),
    .writeRespValid(slvWriteRespValid)
  );

endmodule

//--- hw/sramSlave.sv
`timescale 1ns/100ps

module sramSlave import sramArbPkg::*; #(
  parameter int accessLatency = 3,
  parameter int memWords      = 1024
) (
  input  logic     clk,
  input  logic     rst,
  input  readReq   readReqIn,
  input  logic     readReqValid,
  input  writeReq  writeReqIn,
  input  logic     writeReqValid,
  input  logic     readRespReady,
  input  logic     writeRespReady,
  output logic     readReqReady,
  output logic     writeReqReady,
  output readResp  readRespOut,
  output logic     readRespValid,
  output writeResp writeRespOut,
  output logic     writeRespValid
);

  localparam int idxWidth = (memWords < 2) ? 1 : $clog2(memWords);

  logic [dataWidth-1:0] mem [memWords];

  sramOp   op;
  readReq  rdReqQ;
  writeReq wrReqQ;

  logic                idle;
  logic                readAccept;
  logic                writeAccept;
  logic                readDone;
  logic                writeDone;
  logic                timerBusy;
  logic                timerDone;
  logic                rdInRange;
  logic                wrInRange;
  logic [idxWidth-1:0] rdIdx;
  logic [idxWidth-1:0] wrIdx;

  // ==================================================
  // request select, read before write.
  // ==================================================
  assign idle          = (op == opNone) && !timerBusy;
  assign readReqReady  = idle;
  assign writeReqReady = idle && !readReqValid;
  assign readAccept    = readReqValid && readReqReady;
  assign writeAccept   = writeReqValid && writeReqReady;
  assign readDone      = readRespValid && readRespReady;
  assign writeDone     = writeRespValid && writeRespReady;

  accessTimer #(
    .accessLatency(accessLatency)
  ) timer (
    .clk  (clk),
    .rst  (rst),
    .start(readAccept || writeAccept),
    .busy (timerBusy),
    .done (timerDone)
  );

  // word index from the address above the byte lanes.
  assign rdInRange = (rdReqQ.addr[addrWidth-1:2] < (addrWidth-2)'(memWords));
  assign wrInRange = (wrReqQ.addr[addrWidth-1:2] < (addrWidth-2)'(memWords));
  assign rdIdx     = rdReqQ.addr[idxWidth+1:2];
  assign wrIdx     = wrReqQ.addr[idxWidth+1:2];

  // ==================================================
  // operation and response control.
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      op             <= opNone;
      readRespValid  <= 1'b0;
      writeRespValid <= 1'b0;
    end else begin
      if (readAccept) begin
        op <= opRead;
      end else if (writeAccept) begin
        op <= opWrite;
      end else if (readDone || writeDone) begin
        op <= opNone;
      end
      if (timerDone && op == opRead) begin
        readRespValid <= 1'b1;
      end else if (readDone) begin
        readRespValid <= 1'b0;
      end
      if (timerDone && op == opWrite) begin
        writeRespValid <= 1'b1;
      end else if (writeDone) begin
        writeRespValid <= 1'b0;
      end
    end
  end

  // ==================================================
  // array access and response payload.
  // ==================================================
  always_ff @(posedge clk) begin
    if (readAccept) begin
      rdReqQ <= readReqIn;
    end
    if (writeAccept) begin
      wrReqQ <= writeReqIn;
    end
    if (timerDone && op == opRead) begin
      readRespOut.data <= rdInRange ? mem[rdIdx] : '0;
      readRespOut.resp <= rdInRange ? respOkay : respSlvErr;
    end
    if (timerDone && op == opWrite) begin
      writeRespOut.resp <= wrInRange ? respOkay : respSlvErr;
      for (int b = 0; b < strbWidth; b++) begin
        if (wrInRange && wrReqQ.strb[b]) begin
          mem[wrIdx][b*8 +: 8] <= wrReqQ.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- sramArbiter.f
hw/sramArbPkg.sv
hw/accessTimer.sv
hw/grantFsm.sv
hw/channelRouter.sv
hw/sramSlave.sv
hw/sramArbiter.sv
tests/sramArbiter_checker.sv
tests/sramArbiterTb.sv

//--- tests/sramArbiterTb.sv
`timescale 1ns/100ps

module sramArbiterTb import sramArbPkg::*; ();

  localparam int memWords  = 1024;
  localparam int waitLimit = 200;

  logic     clk = 1'b0;
  logic     rst;
  readReq   readReqA;
  readReq   readReqB;
  logic     readReqValidA;
  logic     readReqValidB;
  logic     readRespReadyA;
  logic     readRespReadyB;
  writeReq  writeReqA;
  writeReq  writeReqB;
  logic     writeReqValidA;
  logic     writeReqValidB;
  logic     writeRespReadyA;
  logic     writeRespReadyB;
  logic     readReqReadyA;
  logic     readReqReadyB;
  readResp  readRespA;
  readResp  readRespB;
  logic     readRespValidA;
  logic     readRespValidB;
  logic     writeReqReadyA;
  logic     writeReqReadyB;
  writeResp writeRespA;
  writeResp writeRespB;
  logic     writeRespValidA;
  logic     writeRespValidB;

  int          seed   = 32'h17cf_64e7;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] shadow [memWords];
  time         firstValidAt [2];
  time         doneAt [2];
  logic [33:0] gotQ [$];
  logic [33:0] expQ [$];
  string       msgQ [$];

  sramArbiter i_dut (.*);

  bind sramArbiter sramArbiter_checker chk (.*);

  always #4 clk = ~clk;

  // ==================================================
  // reference model.
  // ==================================================
  function automatic logic [33:0] expectRead(input logic [31:0] addr);
    if (addr[31:2] >= 30'(memWords)) begin
      return {32'b0, respSlvErr};
    end
    return {shadow[int'(addr[31:2])], respOkay};
  endfunction

  // merges the enabled bytes and returns the expected response code.
  function automatic logic [1:0] writeShadow(input logic [31:0] addr, input logic [31:0] data,
                                             input logic [3:0] strb);
    int idx;
    if (addr[31:2] >= 30'(memWords)) begin
      return respSlvErr;
    end
    idx = int'(addr[31:2]);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return respOkay;
  endfunction

  // ==================================================
  // comparison.
  // ==================================================
  task automatic check(input logic [33:0] got, input logic [33:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic void queueCompare(input logic [33:0] got, input logic [33:0] exp,
                                       input string what);
    gotQ.push_back(got);
    expQ.push_back(exp);
    msgQ.push_back(what);
  endfunction

  always @(negedge clk) begin
    while (gotQ.size() > 0) begin
      check(gotQ.pop_front(), expQ.pop_front(), msgQ.pop_front());
    end
  end

  // ==================================================
  // master side handshakes.
  // ==================================================
  function automatic logic portSig(input bit isB, input int which);
    case (which)
      0: return isB ? readReqReadyB : readReqReadyA;
      1: return isB ? readRespValidB : readRespValidA;
      2: return isB ? writeReqReadyB : writeReqReadyA;
      default: return isB ? writeRespValidB : writeRespValidA;
    endcase
  endfunction

  function automatic logic [33:0] respWord(input bit isB, input bit isWr);
    if (isWr) begin
      return {32'b0, isB ? writeRespB : writeRespA};
    end
    return isB ? readRespB : readRespA;
  endfunction

  function automatic void setRespReady(input bit isB, input bit isWr, input logic v);
    if (isWr && isB) writeRespReadyB = v;
    else if (isWr) writeRespReadyA = v;
    else if (isB) readRespReadyB = v;
    else readRespReadyA = v;
  endfunction

  task automatic waitSig(input bit isB, input int which, input string what);
    int t;
    t = 0;
    @(negedge clk);
    while (!portSig(isB, which) && t < waitLimit) begin
      @(negedge clk);
      t++;
    end
    if (!portSig(isB, which)) begin
      errors++;
      $display("timeout waiting for %s on master %s", what, isB ? "B" : "A");
    end
  endtask

  // holds ready low for stall cycles once the response is valid.
  task automatic takeResp(input bit isB, input bit isWr, input int stall,
                          output logic [33:0] first, output logic [33:0] got);
    waitSig(isB, isWr ? 3 : 1, "response valid");
    firstValidAt[isB] = $time;
    first = respWord(isB, isWr);
    repeat (stall) @(posedge clk);
    @(posedge clk);
    #1;
    setRespReady(isB, isWr, 1'b1);
    @(negedge clk);
    queueCompare(34'(portSig(isB, isWr ? 3 : 1)), 34'd1, "response valid until ready");
    got = respWord(isB, isWr);
    @(posedge clk);
    doneAt[isB] = $time;
    #1;
    setRespReady(isB, isWr, 1'b0);
  endtask

  task automatic readWord(input bit isB, input logic [31:0] addr, input int stall);
    logic [33:0] first;
    logic [33:0] got;
    @(posedge clk);
    #1;
    if (isB) begin
      readReqB.addr = addr;
      readReqValidB = 1'b1;
    end else begin
      readReqA.addr = addr;
      readReqValidA = 1'b1;
    end
    waitSig(isB, 0, "read request ready");
    @(posedge clk);
    #1;
    if (isB) readReqValidB = 1'b0;
    else readReqValidA = 1'b0;
    takeResp(isB, 1'b0, stall, first, got);
    queueCompare(got, first, "read response held");
    queueCompare(got, expectRead(addr), $sformatf("read of %h", addr));
  endtask

  task automatic writeWord(input bit isB, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int stall);
    logic [33:0] first;
    logic [33:0] got;
    writeReq     req;
    req = '{addr: addr, data: data, strb: strb};
    @(posedge clk);
    #1;
    if (isB) begin
      writeReqB      = req;
      writeReqValidB = 1'b1;
    end else begin
      writeReqA      = req;
      writeReqValidA = 1'b1;
    end
    waitSig(isB, 2, "write request ready");
    @(posedge clk);
    #1;
    if (isB) writeReqValidB = 1'b0;
    else writeReqValidA = 1'b0;
    takeResp(isB, 1'b1, stall, first, got);
    queueCompare(got, first, "write response held");
    queueCompare(got, {32'b0, writeShadow(addr, data, strb)}, $sformatf("write to %h", addr));
  endtask

  // A stays in the lower half of the array and B in the upper half.
  task automatic randomTraffic(input bit isB, input int count);
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          stall;
    for (int n = 0; n < count; n++) begin
      r     = $random(seed);
      addr  = {20'b0, isB, r[8:0], 2'b00};
      data  = $random(seed);
      r     = $random(seed);
      strb  = r[3:0];
      stall = int'(r[5:4]);
      if (r[8]) writeWord(isB, addr, data, strb, stall);
      else readWord(isB, addr, stall);
    end
  endtask

  // ==================================================
  // test sequence.
  // ==================================================
  initial begin
    logic [31:0] a;
    logic [31:0] r;
    rst             = 1'b1;
    readReqA        = '0;
    readReqB        = '0;
    readReqValidA   = 1'b0;
    readReqValidB   = 1'b0;
    readRespReadyA  = 1'b0;
    readRespReadyB  = 1'b0;
    writeReqA       = '0;
    writeReqB       = '0;
    writeReqValidA  = 1'b0;
    writeReqValidB  = 1'b0;
    writeRespReadyA = 1'b0;
    writeRespReadyB = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // fill every word so later reads have known contents.
    for (int w = 0; w < memWords; w++) begin
      a = 32'(w * 4);
      writeWord(1'b0, a, a * 32'h9e37_79b1 + 32'h1357_2468, 4'hf, 0);
    end

    // full then partial strobes, read back.
    writeWord(1'b0, 32'h40, 32'h1234_5678, 4'hf, 0);
    writeWord(1'b0, 32'h40, 32'haabb_ccdd, 4'b0101, 0);
    writeWord(1'b0, 32'h40, 32'h9900_0000, 4'b1000, 0);
    readWord(1'b0, 32'h40, 0);

    fork
      readWord(1'b0, 32'h100, 0);
      readWord(1'b1, 32'h0c00, 0);
    join
    queueCompare(34'(firstValidAt[1] > doneAt[0]), 34'd1, "A read ends before B response");

    // out of range, the first one would alias word 0.
    writeWord(1'b0, 32'h1000, 32'h5555_aaaa, 4'hf, 0);
    readWord(1'b0, 32'h1000, 0);
    writeWord(1'b1, 32'hffff_fffc, 32'h0f0f_0f0f, 4'hf, 0);
    readWord(1'b1, 32'hffff_fffc, 0);
    readWord(1'b0, 32'h0, 0);
    readWord(1'b1, 32'h0ffc, 0);

    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      readWord(1'b1, {20'b0, 1'b1, r[8:0], 2'b00}, int'(r[31:16] % 16'd11));
      r = $random(seed);
      writeWord(1'b0, {20'b0, 1'b0, r[8:0], 2'b00}, r, 4'hf, int'(r[31:16] % 16'd11));
    end

    fork
      randomTraffic(1'b0, 100);
      randomTraffic(1'b1, 100);
    join

    repeat (2) @(negedge clk);
    errors += i_dut.chk.fails;
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tests/sramArbiter_checker.sv
`timescale 1ns/100ps

module sramArbiter_checker import sramArbPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     readRespValidA,
  input logic     readRespValidB,
  input logic     readRespReadyA,
  input logic     readRespReadyB,
  input readResp  readRespA,
  input readResp  readRespB,
  input logic     writeRespValidA,
  input logic     writeRespValidB,
  input logic     writeRespReadyA,
  input logic     writeRespReadyB,
  input writeResp writeRespA,
  input writeResp writeRespB
);

  int fails = 0;

  // ==================================================
  // one owner per channel.
  // ==================================================
  readOwner: assert property (@(posedge clk) disable iff (rst)
      !(readRespValidA && readRespValidB)) else begin
    fails++;
    $error("read response valid at both masters");
  end

  writeOwner: assert property (@(posedge clk) disable iff (rst)
      !(writeRespValidA && writeRespValidB)) else begin
    fails++;
    $error("write response valid at both masters");
  end

  // ==================================================
  // response held under back-pressure.
  // ==================================================
  readHoldA: assert property (@(posedge clk) disable iff (rst)
      readRespValidA && !readRespReadyA |=> readRespValidA && $stable(readRespA)) else begin
    fails++;
    $error("read response of master A changed before ready");
  end

  readHoldB: assert property (@(posedge clk) disable iff (rst)
      readRespValidB && !readRespReadyB |=> readRespValidB && $stable(readRespB)) else begin
    fails++;
    $error("read response of master B changed before ready");
  end

  writeHoldA: assert property (@(posedge clk) disable iff (rst)
      writeRespValidA && !writeRespReadyA |=> writeRespValidA && $stable(writeRespA)) else begin
    fails++;
    $error("write response of master A changed before ready");
  end

  writeHoldB: assert property (@(posedge clk) disable iff (rst)
      writeRespValidB && !writeRespReadyB |=> writeRespValidB && $stable(writeRespB)) else begin
    fails++;
    $error("write response of master B changed before ready");
  end

  // nothing comes back right after reset.
  quietAfterReset: assert property (@(posedge clk)
      $fell(rst) |-> !(readRespValidA || readRespValidB || writeRespValidA || writeRespValidB))
      else begin
    fails++;
    $error("response valid in the cycle after reset");
  end

endmodule
